// File: include/frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// ----------------------------------------------------------------------
// Front end build constants
// ----------------------------------------------------------------------

// Signed ADC sample width
`define SAMPLE_W 12

// Samples per FFT frame
// 256 also supported by the frame counter width
`define FRAME_LEN 16

// Sample FIFO entries, power of two
`define FIFO_DEPTH 64

// Core reset hold after rst_n release, in clk_50m cycles
`define STARTUP_CYCLES 32

`endif

// File: logic/frontend_pkg.sv
`include "frontend_consts.svh"

package frontend_pkg;

    // ------------------------------------------------------------------
    // Scalar widths
    // ------------------------------------------------------------------

    // Raw ADC sample, two's complement
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // Absolute sample value
    typedef logic [`SAMPLE_W-1:0] mag_t;

    // Position in frame, 1 .. FRAME_LEN, 0 before the first read
    typedef logic [$clog2(`FRAME_LEN + 1)-1:0] frame_cnt_t;

    // Running frame number, wraps
    typedef logic [15:0] frame_idx_t;

    // Frame controller states
    typedef enum logic {
        ST_STARTUP = 1'b0,
        ST_RUN     = 1'b1
    } ctrl_state_t;

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------

    // Framed sample stream towards the FFT core
    typedef struct packed {
        logic    valid;
        logic    sop;
        logic    eop;
        sample_t data;
    } fft_stream_t;

    // Per-frame peak result, valid for one cycle
    typedef struct packed {
        logic       valid;
        mag_t       peak;
        frame_idx_t frame;
    } peak_report_t;

endpackage

// File: logic/sample_fifo.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module sample_fifo (
    input  logic                  clk_50m,
    input  logic                  rst_n,
    // ADC side
    input  logic                  wr_en,
    input  frontend_pkg::sample_t wr_data,
    // Controller side
    input  logic                  rd_req,
    output frontend_pkg::sample_t rd_data,
    output logic                  empty,
    // Sticky loss flag
    output logic                  overflow
);

    import frontend_pkg::*;

    // Address bits, pointers carry one more for full/empty
    localparam int ADDR_W = $clog2(`FIFO_DEPTH);

    // ------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------

    sample_t           mem [`FIFO_DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              full;
    logic              do_write;
    logic              do_read;

    // Same address, wrap bits differ -> full
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    // Pointers fully equal -> empty
    assign empty = (wr_ptr == rd_ptr);

    // Accepted strobe
    assign do_write = wr_en && !full;
    // Read guarded again, controller already gates on empty
    assign do_read  = rd_req && !empty;

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------

    // Sample storage
    always_ff @(posedge clk_50m) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Strobe into a full FIFO, sample dropped, flag held until reset
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Registered output word
    // Appears one cycle after rd_req
    always_ff @(posedge clk_50m) begin
        if (do_read) begin
            rd_data <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

// File: logic/frame_ctrl.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frame_ctrl (
    input  logic                      clk_50m,
    input  logic                      rst_n,
    // FIFO handshake
    input  logic                      empty,
    output logic                      rd_req,
    // FFT core control
    input  logic                      fft_ready,
    output logic                      fft_rst_n,
    // Stream control fields, data left at zero
    output frontend_pkg::fft_stream_t ctrl_out
);

    import frontend_pkg::*;

    // Start-up counter width, at least one bit
    localparam int DLY_W = ($clog2(`STARTUP_CYCLES) > 0) ? $clog2(`STARTUP_CYCLES) : 1;

    // Last count of the start-up delay
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`STARTUP_CYCLES - 1);

    // Frame boundaries in counter terms
    localparam frame_cnt_t CNT_FIRST = frame_cnt_t'(1);
    localparam frame_cnt_t CNT_LAST  = frame_cnt_t'(`FRAME_LEN);

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------

    ctrl_state_t        state;
    logic [DLY_W-1:0]   dly_cnt;
    logic               dly_done;
    logic               rd_en;
    logic               fft_valid;
    frame_cnt_t         frame_cnt;
    logic               sop;
    logic               eop;

    // Delay expired, counter parks at its last value
    assign dly_done = (dly_cnt == DLY_LAST);

    // Request only what the FIFO can give this cycle
    assign rd_req = rd_en && !empty;

    // Markers follow the count of the sample now on the bus
    assign sop = fft_valid && (frame_cnt == CNT_FIRST);
    assign eop = fft_valid && (frame_cnt == CNT_LAST);

    assign ctrl_out = '{
        valid: fft_valid,
        sop:   sop,
        eop:   eop,
        data:  '0
    };

    // ------------------------------------------------------------------
    // Controller FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_STARTUP;
            dly_cnt   <= '0;
            fft_rst_n <= 1'b0;
            rd_en     <= 1'b0;
            fft_valid <= 1'b0;
            frame_cnt <= '0;
        end else begin
            case (state)
                ST_STARTUP: begin
                    // Nothing leaves the FIFO yet
                    rd_en     <= 1'b0;
                    fft_valid <= 1'b0;
                    frame_cnt <= '0;

                    // Core held in reset for the start-up delay
                    if (!dly_done) begin
                        dly_cnt   <= dly_cnt + 1'b1;
                        fft_rst_n <= 1'b0;
                    end else begin
                        fft_rst_n <= 1'b1;
                    end

                    // Ready only looked at here
                    if (dly_done && fft_ready) begin
                        state <= ST_RUN;
                    end
                end

                ST_RUN: begin
                    // Read enable follows FIFO fill, one cycle late
                    rd_en <= !empty;

                    // Word lands on rd_data next cycle, valid with it
                    if (rd_req) begin
                        fft_valid <= 1'b1;
                        if (frame_cnt < CNT_LAST) begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end else begin
                            frame_cnt <= CNT_FIRST;
                        end
                    end else begin
                        fft_valid <= 1'b0;
                    end
                end

                default: begin
                    state <= ST_STARTUP;
                end
            endcase
        end
    end

endmodule

// File: logic/frame_peak.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frame_peak (
    input  logic                       clk_50m,
    input  logic                       rst_n,
    // Observed framed stream
    input  frontend_pkg::fft_stream_t  stream_in,
    // One report per frame
    output frontend_pkg::peak_report_t peak_out
);

    import frontend_pkg::*;

    // Most negative input code and its saturated magnitude
    localparam sample_t MOST_NEG = {1'b1, {(`SAMPLE_W-1){1'b0}}};
    localparam mag_t    MAG_SAT  = {1'b0, {(`SAMPLE_W-1){1'b1}}};

    mag_t       abs_mag;
    mag_t       run_max;
    mag_t       next_max;
    logic       rpt_valid;
    mag_t       rpt_peak;
    frame_idx_t rpt_frame;
    frame_idx_t frame_num;

    // ------------------------------------------------------------------
    // Magnitude and running maximum
    // ------------------------------------------------------------------

    // Absolute value, most negative code clipped
    always_comb begin
        if (!stream_in.data[`SAMPLE_W-1]) begin
            abs_mag = mag_t'(stream_in.data);
        end else if (stream_in.data == MOST_NEG) begin
            abs_mag = MAG_SAT;
        end else begin
            abs_mag = mag_t'(-stream_in.data);
        end
    end

    // sop restarts the max with the current sample
    assign next_max = (stream_in.sop || (abs_mag > run_max)) ? abs_mag : run_max;

    always_ff @(posedge clk_50m) begin
        if (stream_in.valid) begin
            run_max <= next_max;
        end
        // Final max of the frame, eop sample included
        if (stream_in.valid && stream_in.eop) begin
            rpt_peak  <= next_max;
            rpt_frame <= frame_num;
        end
    end

    // ------------------------------------------------------------------
    // Report strobe and frame number
    // ------------------------------------------------------------------

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            rpt_valid <= 1'b0;
            frame_num <= '0;
        end else begin
            rpt_valid <= stream_in.valid && stream_in.eop;
            if (stream_in.valid && stream_in.eop) begin
                frame_num <= frame_num + 1'b1;
            end
        end
    end

    assign peak_out = '{valid: rpt_valid, peak: rpt_peak, frame: rpt_frame};

endmodule

// File: logic/fft_frontend_top.sv
`timescale 1ns/1ps

module fft_frontend_top (
    input  logic                       clk_50m,
    input  logic                       rst_n,
    // ADC strobe and sample
    input  logic                       adc_valid,
    input  frontend_pkg::sample_t      adc_data,
    // FFT core side
    input  logic                       fft_ready,
    output logic                       fft_rst_n,
    output frontend_pkg::fft_stream_t  fft_out,
    // Monitoring
    output frontend_pkg::peak_report_t peak_out,
    output logic                       fifo_overflow
);

    import frontend_pkg::*;

    // ------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------

    logic        fifo_empty;
    logic        fifo_rd_req;
    sample_t     fifo_rd_data;
    fft_stream_t ctrl_stream;

    // Sample buffer between ADC and core
    sample_fifo u_fifo (
        .clk_50m  (clk_50m),
        .rst_n    (rst_n),
        .wr_en    (adc_valid),
        .wr_data  (adc_data),
        .rd_req   (fifo_rd_req),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .overflow (fifo_overflow)
    );

    // Core reset, ready wait, draining and framing
    frame_ctrl u_ctrl (
        .clk_50m   (clk_50m),
        .rst_n     (rst_n),
        .empty     (fifo_empty),
        .rd_req    (fifo_rd_req),
        .fft_ready (fft_ready),
        .fft_rst_n (fft_rst_n),
        .ctrl_out  (ctrl_stream)
    );

    // Controller markers merged with the registered FIFO word
    assign fft_out = '{
        valid: ctrl_stream.valid,
        sop:   ctrl_stream.sop,
        eop:   ctrl_stream.eop,
        data:  fifo_rd_data
    };

    // Per-frame peak on the outgoing stream
    frame_peak u_peak (
        .clk_50m   (clk_50m),
        .rst_n     (rst_n),
        .stream_in (fft_out),
        .peak_out  (peak_out)
    );

endmodule

// File: verif/tb_frontend_model.svh
`ifndef TB_FRONTEND_MODEL_SVH
`define TB_FRONTEND_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model state
// ----------------------------------------------------------------------

// Expected stream words and peak reports, oldest first
fft_stream_t  exp_stream_q [$];
peak_report_t exp_peak_q [$];

// Position of the last accepted sample in its frame, 0 at frame start
int           frame_pos;
mag_t         frame_max;
frame_idx_t   exp_frame_num;
// Samples parked in the FIFO while the core is not running
int           held_count;
bit           exp_overflow;

// Magnitude clipped to the largest positive code
function automatic mag_t abs_saturated(sample_t s);
    int v;
    int limit;
    v     = s;
    limit = (1 << (`SAMPLE_W - 1)) - 1;
    if (v < 0) begin
        v = -v;
    end
    if (v > limit) begin
        v = limit;
    end
    return mag_t'(v);
endfunction

// Fresh reset phase, nothing pending
task automatic clear_expectations();
    exp_stream_q.delete();
    exp_peak_q.delete();
    frame_pos     = 0;
    frame_max     = '0;
    exp_frame_num = '0;
    held_count    = 0;
    exp_overflow  = 1'b0;
endtask

// One ADC strobe; running says whether the controller drains the FIFO
task automatic record_write(sample_t s, bit running);
    mag_t        m;
    fft_stream_t word;
    // Full FIFO with no reader drops the sample
    if (!running && held_count >= `FIFO_DEPTH) begin
        exp_overflow = 1'b1;
        return;
    end
    if (!running) begin
        held_count++;
    end
    frame_pos++;
    m = abs_saturated(s);
    if (frame_pos == 1 || m > frame_max) begin
        frame_max = m;
    end
    word.valid = 1'b1;
    word.sop   = (frame_pos == 1);
    word.eop   = (frame_pos == `FRAME_LEN);
    word.data  = s;
    exp_stream_q.push_back(word);
    // Frame complete, report follows its eop
    if (frame_pos == `FRAME_LEN) begin
        exp_peak_q.push_back('{valid: 1'b1, peak: frame_max, frame: exp_frame_num});
        exp_frame_num++;
        frame_pos = 0;
    end
endtask

`endif

// File: verif/tb_fft_frontend.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module tb_fft_frontend;

    import frontend_pkg::*;

    typedef enum int {PAT_RAMP, PAT_ALT, PAT_SPIKE, PAT_NEG, PAT_RAND} pattern_t;

    logic         clk_50m;
    logic         rst_n;
    logic         adc_valid;
    sample_t      adc_data;
    logic         fft_ready;
    logic         fft_rst_n;
    fft_stream_t  fft_out;
    peak_report_t peak_out;
    logic         fifo_overflow;

    int seed = 20599;
    int error_count;
    int check_count;
    int row_out_count;
    bit ready_raised;
    bit core_rst_released;
    // eop seen on the stream at the previous sample point
    bit eop_last;

    `include "tb_frontend_model.svh"

    // ------------------------------------------------------------------
    // Stimulus table, one reset phase per row
    // ------------------------------------------------------------------

    localparam int NUM_ROWS = 6;
    string    row_name  [NUM_ROWS] = '{"ramp_dense", "alt_sparse", "spike", "most_neg",
                                       "random", "overflow"};
    bit       row_ready [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
    int       row_count [NUM_ROWS] = '{48, 32, 16, 16, 64, 80};
    // Cycles from one strobe to the next, 1 is back to back
    int       row_every [NUM_ROWS] = '{1, 3, 2, 1, 2, 1};
    pattern_t row_pat   [NUM_ROWS] = '{PAT_RAMP, PAT_ALT, PAT_SPIKE, PAT_NEG,
                                       PAT_RAND, PAT_RAMP};

    fft_frontend_top u_dut (
        .clk_50m       (clk_50m),
        .rst_n         (rst_n),
        .adc_valid     (adc_valid),
        .adc_data      (adc_data),
        .fft_ready     (fft_ready),
        .fft_rst_n     (fft_rst_n),
        .fft_out       (fft_out),
        .peak_out      (peak_out),
        .fifo_overflow (fifo_overflow)
    );

    // 50 MHz
    always #10 clk_50m = ~clk_50m;

    task automatic check_value(bit ok, string what);
        check_count++;
        assert (ok) else begin
            $display("mismatch at %0t: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic check_condition(bit ok, string what);
        check_count++;
        assert (ok) else begin
            $display("error at %0t: %s", $time, what);
            error_count++;
        end
    endtask

    function automatic sample_t make_sample(pattern_t pat, int idx);
        int r;
        case (pat)
            PAT_RAMP:  r = idx * 25 - 1000;
            PAT_ALT:   r = idx[0] ? -(idx * 37 + 11) : (idx * 37 + 5);
            PAT_SPIKE: r = (idx == 9) ? -1234 : 3;
            PAT_NEG:   r = idx[0] ? -(1 << (`SAMPLE_W - 1)) : idx * 50;
            default:   r = $random(seed);
        endcase
        return sample_t'(r);
    endfunction

    // ------------------------------------------------------------------
    // Scoreboard, sampled mid-cycle
    // ------------------------------------------------------------------

    always @(negedge clk_50m) begin
        if (!rst_n) begin
            core_rst_released = 1'b0;
            eop_last          = 1'b0;
        end else begin
            if (fft_rst_n) begin
                core_rst_released = 1'b1;
            end else if (core_rst_released) begin
                check_condition(1'b0, "fft_rst_n went low again after start-up");
            end
            if ((fft_out.sop || fft_out.eop) && !fft_out.valid) begin
                check_condition(1'b0, "sop or eop raised without valid");
            end
            if (fft_out.valid) begin
                row_out_count++;
                check_condition(ready_raised, "stream valid seen before fft_ready was raised");
                if (exp_stream_q.size() == 0) begin
                    check_condition(1'b0, "stream sample appeared with none pending");
                end else begin
                    check_value(fft_out == exp_stream_q[0],
                        $sformatf("stream got sop=%0b eop=%0b data=%0d, expected %0b %0b %0d",
                                  fft_out.sop, fft_out.eop, fft_out.data, exp_stream_q[0].sop,
                                  exp_stream_q[0].eop, exp_stream_q[0].data));
                    void'(exp_stream_q.pop_front());
                end
            end
            // Report strobe exactly one cycle behind each eop
            if (peak_out.valid != eop_last) begin
                check_condition(1'b0, "peak report valid not exactly one cycle after eop");
            end
            eop_last = fft_out.valid && fft_out.eop;
            if (peak_out.valid) begin
                if (exp_peak_q.size() == 0) begin
                    check_condition(1'b0, "peak report appeared with no frame finished");
                end else begin
                    check_value(peak_out == exp_peak_q[0],
                        $sformatf("peak got %0d frame %0d, expected %0d frame %0d",
                                  peak_out.peak, peak_out.frame, exp_peak_q[0].peak,
                                  exp_peak_q[0].frame));
                    void'(exp_peak_q.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Phase steps
    // ------------------------------------------------------------------

    // Two reset cycles, then measure the core reset hold
    task automatic apply_reset(bit ready);
        int low_cycles;
        rst_n        = 1'b0;
        adc_valid    = 1'b0;
        adc_data     = '0;
        fft_ready    = ready;
        ready_raised = ready;
        @(negedge clk_50m);
        @(negedge clk_50m);
        check_value(!fft_rst_n && !fft_out.valid && !peak_out.valid && !fifo_overflow,
                    "outputs not at reset values during rst_n");
        clear_expectations();
        row_out_count = 0;
        rst_n = 1'b1;
        low_cycles = 0;
        while (!fft_rst_n && low_cycles <= `STARTUP_CYCLES + 8) begin
            low_cycles++;
            @(negedge clk_50m);
        end
        check_value(low_cycles == `STARTUP_CYCLES,
                    $sformatf("fft_rst_n low for %0d cycles, expected %0d",
                              low_cycles, `STARTUP_CYCLES));
    endtask

    task automatic drive_samples(int row);
        sample_t s;
        for (int i = 0; i < row_count[row]; i++) begin
            s         = make_sample(row_pat[row], i);
            adc_valid = 1'b1;
            adc_data  = s;
            record_write(s, fft_ready);
            @(negedge clk_50m);
            adc_valid = 1'b0;
            repeat (row_every[row] - 1) @(negedge clk_50m);
        end
        adc_valid = 1'b0;
    endtask

    // Everything expected has come out, then a quiet tail for extras
    task automatic wait_drained();
        while (exp_stream_q.size() != 0 || exp_peak_q.size() != 0) begin
            @(negedge clk_50m);
        end
        repeat (6) @(negedge clk_50m);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int errors_before;
        clk_50m       = 1'b0;
        rst_n         = 1'b0;
        adc_valid     = 1'b0;
        adc_data      = '0;
        fft_ready     = 1'b0;
        error_count   = 0;
        check_count   = 0;
        row_out_count = 0;
        clear_expectations();
        for (int row = 0; row < NUM_ROWS; row++) begin
            errors_before = error_count;
            apply_reset(row_ready[row]);
            drive_samples(row);
            if (!row_ready[row]) begin
                // Core still held off, FIFO must have filled and dropped
                repeat (4) @(negedge clk_50m);
                check_value(fifo_overflow == exp_overflow,
                            $sformatf("fifo_overflow %0b before ready, expected %0b",
                                      fifo_overflow, exp_overflow));
                fft_ready    = 1'b1;
                ready_raised = 1'b1;
            end
            wait_drained();
            // Sticky flag survives the drain
            check_value(fifo_overflow == exp_overflow,
                        $sformatf("fifo_overflow %0b at phase end, expected %0b",
                                  fifo_overflow, exp_overflow));
            $display("test %0d %s: %0d samples out, %0d errors", row, row_name[row],
                     row_out_count, error_count - errors_before);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Four cycles per sample plus fixed slack
    initial begin
        int limit;
        limit = 500;
        for (int row = 0; row < NUM_ROWS; row++) begin
            limit += row_count[row] * 4;
        end
        repeat (limit) @(posedge clk_50m);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
+incdir+verif
logic/frontend_pkg.sv
logic/sample_fifo.sv
logic/frame_ctrl.sv
logic/frame_peak.sv
logic/fft_frontend_top.sv
verif/tb_fft_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_fft_frontend \
    -Mdir obj_dir \
    -o sim_tb

sim_out="$(./obj_dir/sim_tb)"
echo "$sim_out"

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
